//--- design/exec_consts.svh
// ----------------------------------------
// Width constants for the execute stage
// XLEN must stay 32; the ALU shifts and the
// multiplier step count assume it
// ----------------------------------------

`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Datapath
`define XLEN 32

// Tag widths
`define SEQ_NUM_BITS   8   // In-flight op tag
`define PHYS_ADDR_BITS 6   // 64 physical regs
`define ARCH_ADDR_BITS 5   // x0..x31

`endif

//--- design/exec_pkg.sv
// ----------------------------------------
// Shared types for the execute stage
// Opcode encoding is fixed at 4 bits
// ----------------------------------------

`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

  // ----------------------------------------
  // Micro-op encoding
  // ----------------------------------------

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLT,    // Signed compare
    OP_SLTU,   // Unsigned compare
    OP_SRA,
    OP_SRL,
    OP_SLL,
    OP_LUI,    // op2 carries the upper immediate
    OP_AUIPC,  // pc + op2
    OP_MUL,    // Low product word
    OP_MULHU   // High word, both operands unsigned
  } rv_uop;

  // ----------------------------------------
  // Data and tag types
  // ----------------------------------------

  typedef logic [`XLEN-1:0]           word_t;
  typedef logic [`SEQ_NUM_BITS-1:0]   seq_num_t;   // Result order tag
  typedef logic [`PHYS_ADDR_BITS-1:0] preg_t;
  typedef logic [`ARCH_ADDR_BITS-1:0] areg_t;

  // Only the multiply class leaves the ALU path
  // Everything else is single cycle

endpackage

`default_nettype wire

//--- design/exec_dispatch.sv
// ----------------------------------------
// Steers issue valid to ALU or multiplier
// Purely combinational, payload not routed here
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_dispatch
  import exec_pkg::*;
(
  // Issue side
  input  logic  d_val,
  input  rv_uop d_uop,
  output logic  d_rdy,

  // ALU channel
  output logic  alu_val,
  input  logic  alu_rdy,

  // Multiplier channel
  output logic  mul_val,
  input  logic  mul_rdy
);

  // ----------------------------------------
  // Opcode class decode
  // ----------------------------------------

  logic is_mul;   // MUL or MULHU

  always_comb begin
    case (d_uop)
      OP_MUL,
      OP_MULHU: is_mul = 1'b1;
      default:  is_mul = 1'b0;   // All integer ops
    endcase
  end

  // ----------------------------------------
  // Valid steering and ready return
  // ----------------------------------------

  // Only the selected unit sees a valid
  assign alu_val = d_val & ~is_mul;
  assign mul_val = d_val &  is_mul;

  // Ready follows the opcode, not d_val
  // Op simply waits at d if its unit is busy
  assign d_rdy = is_mul ? mul_rdy : alu_rdy;

endmodule

`default_nettype wire

//--- design/alu_unit.sv
// ----------------------------------------
// Single-entry integer unit, 1-cycle latency
// Expects only non-multiply ops on its input
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module alu_unit
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // Input from dispatcher
  input  logic     in_val,
  output logic     in_rdy,
  input  word_t    in_pc,
  input  seq_num_t in_seq_num,
  input  word_t    in_op1,
  input  word_t    in_op2,
  input  areg_t    in_waddr,
  input  rv_uop    in_uop,
  input  preg_t    in_preg,
  input  preg_t    in_ppreg,

  // Result to writeback arbiter
  output logic     out_val,
  input  logic     out_rdy,
  output word_t    out_pc,
  output seq_num_t out_seq_num,
  output areg_t    out_waddr,
  output preg_t    out_preg,
  output preg_t    out_ppreg,
  output word_t    out_wdata
);

  // ----------------------------------------
  // Input register
  // ----------------------------------------

  logic  in_xfer;
  logic  out_xfer;
  logic  full;        // Entry holds an op
  word_t op1_q;
  word_t op2_q;
  rv_uop uop_q;

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;

  // Empty, or being drained this cycle
  assign in_rdy = out_rdy | ~full;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (in_xfer) begin
      full <= 1'b1;      // Load wins over drain
    end else if (out_xfer) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_pc      <= in_pc;
      out_seq_num <= in_seq_num;
      out_waddr   <= in_waddr;
      out_preg    <= in_preg;
      out_ppreg   <= in_ppreg;
      op1_q       <= in_op1;
      op2_q       <= in_op2;
      uop_q       <= in_uop;
    end
  end

  // ----------------------------------------
  // Integer operations
  // ----------------------------------------

  always_comb begin
    case (uop_q)
      OP_ADD:   out_wdata = op1_q + op2_q;
      OP_SUB:   out_wdata = op1_q - op2_q;
      OP_AND:   out_wdata = op1_q & op2_q;
      OP_OR:    out_wdata = op1_q | op2_q;
      OP_XOR:   out_wdata = op1_q ^ op2_q;
      OP_SLT:   out_wdata = {{(`XLEN-1){1'b0}}, $signed(op1_q) < $signed(op2_q)};
      OP_SLTU:  out_wdata = {{(`XLEN-1){1'b0}}, op1_q < op2_q};
      OP_SRA:   out_wdata = $signed(op1_q) >>> op2_q[4:0];   // Shamt is low 5 bits
      OP_SRL:   out_wdata = op1_q >> op2_q[4:0];
      OP_SLL:   out_wdata = op1_q << op2_q[4:0];
      OP_LUI:   out_wdata = op2_q;             // Immediate already shifted
      OP_AUIPC: out_wdata = out_pc + op2_q;
      default:  out_wdata = '0;                // Multiply never lands here
    endcase
  end

  assign out_val = full;

endmodule

`default_nettype wire

//--- design/mul_unit.sv
// ----------------------------------------
// Unsigned shift-add multiplier, one op at a time
// Result 32 cycles after capture, MUL or MULHU
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module mul_unit
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // Input from dispatcher
  input  logic     in_val,
  output logic     in_rdy,
  input  word_t    in_pc,
  input  seq_num_t in_seq_num,
  input  word_t    in_op1,
  input  word_t    in_op2,
  input  areg_t    in_waddr,
  input  rv_uop    in_uop,
  input  preg_t    in_preg,
  input  preg_t    in_ppreg,

  // Result to writeback arbiter
  output logic     out_val,
  input  logic     out_rdy,
  output word_t    out_pc,
  output seq_num_t out_seq_num,
  output areg_t    out_waddr,
  output preg_t    out_preg,
  output preg_t    out_ppreg,
  output word_t    out_wdata
);

  // ----------------------------------------
  // Control
  // ----------------------------------------

  logic                 in_xfer;
  logic                 out_xfer;
  logic                 busy;     // Stepping
  logic                 done;     // Result waiting
  logic [4:0]           step;     // 0..31
  logic                 hi_q;     // MULHU selects upper word
  logic [2*`XLEN-1:0]   mcand;    // Multiplicand, shifts left
  word_t                mplier;   // Multiplier, shifts right
  logic [2*`XLEN-1:0]   acc;

  assign in_xfer  = in_val & in_rdy;
  assign out_xfer = out_val & out_rdy;
  assign in_rdy   = ~busy & ~done;   // Accept only when fully empty

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else if (in_xfer) begin
      busy <= 1'b1;
      step <= '0;
    end else if (busy) begin
      step <= step + 5'd1;
      if (step == 5'd31) begin   // Last partial product this edge
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else if (out_xfer) begin
      done <= 1'b0;
    end
  end

  // ----------------------------------------
  // Datapath
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (in_xfer) begin
      out_pc      <= in_pc;
      out_seq_num <= in_seq_num;
      out_waddr   <= in_waddr;
      out_preg    <= in_preg;
      out_ppreg   <= in_ppreg;
      hi_q        <= (in_uop == OP_MULHU);
      mcand       <= {{`XLEN{1'b0}}, in_op1};   // Zero-extended, unsigned
      mplier      <= in_op2;
      acc         <= '0;
    end else if (busy) begin
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign out_val   = done;
  assign out_wdata = hi_q ? acc[2*`XLEN-1:`XLEN] : acc[`XLEN-1:0];

endmodule

`default_nettype wire

//--- design/wb_arbiter.sv
// ----------------------------------------
// Round-robin merge of two result streams
// Source readies never look at their own valid
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module wb_arbiter
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // Source a
  input  logic     a_val,
  output logic     a_rdy,
  input  word_t    a_pc,
  input  seq_num_t a_seq_num,
  input  areg_t    a_waddr,
  input  preg_t    a_preg,
  input  preg_t    a_ppreg,
  input  word_t    a_wdata,

  // Source b
  input  logic     b_val,
  output logic     b_rdy,
  input  word_t    b_pc,
  input  seq_num_t b_seq_num,
  input  areg_t    b_waddr,
  input  preg_t    b_preg,
  input  preg_t    b_ppreg,
  input  word_t    b_wdata,

  // Writeback port
  output logic     w_val,
  input  logic     w_rdy,
  output word_t    w_pc,
  output seq_num_t w_seq_num,
  output areg_t    w_waddr,
  output preg_t    w_preg,
  output preg_t    w_ppreg,
  output word_t    w_wdata
);

  logic last_b;   // b won the last transfer
  logic sel_b;

  // ----------------------------------------
  // Grant
  // ----------------------------------------

  assign sel_b = b_val & (~a_val | ~last_b);   // b if alone or its turn
  assign a_rdy = w_rdy & (~b_val | last_b);
  assign b_rdy = w_rdy & (~a_val | ~last_b);

  // Pointer moves only when something leaves
  always_ff @(posedge clk) begin
    if (rst) last_b <= 1'b0;
    else if (w_val & w_rdy) last_b <= sel_b;
  end

  // ----------------------------------------
  // Output mux
  // ----------------------------------------

  assign w_val     = a_val | b_val;
  assign w_pc      = sel_b ? b_pc      : a_pc;
  assign w_seq_num = sel_b ? b_seq_num : a_seq_num;
  assign w_waddr   = sel_b ? b_waddr   : a_waddr;
  assign w_preg    = sel_b ? b_preg    : a_preg;
  assign w_ppreg   = sel_b ? b_ppreg   : a_ppreg;
  assign w_wdata   = sel_b ? b_wdata   : a_wdata;

endmodule

`default_nettype wire

//--- design/exec_stage.sv
// ----------------------------------------
// Execute stage top, ALU and multiplier
// Results may retire out of order, match by seq_num
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_stage
  import exec_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  // Issue port
  input  logic     d_val,
  output logic     d_rdy,
  input  word_t    d_pc,
  input  seq_num_t d_seq_num,
  input  word_t    d_op1,
  input  word_t    d_op2,
  input  areg_t    d_waddr,
  input  rv_uop    d_uop,
  input  preg_t    d_preg,
  input  preg_t    d_ppreg,

  // Writeback port
  output logic     w_val,
  input  logic     w_rdy,
  output word_t    w_pc,
  output seq_num_t w_seq_num,
  output areg_t    w_waddr,
  output preg_t    w_preg,
  output preg_t    w_ppreg,
  output word_t    w_wdata
);

  // ----------------------------------------
  // Internal channels
  // ----------------------------------------

  logic     alu_val, alu_rdy, mul_val, mul_rdy;             // Dispatch side
  logic     ar_val, ar_rdy, mr_val, mr_rdy;                 // Result side
  word_t    ar_pc, ar_wdata, mr_pc, mr_wdata;
  seq_num_t ar_seq_num, mr_seq_num;
  areg_t    ar_waddr, mr_waddr;
  preg_t    ar_preg, ar_ppreg, mr_preg, mr_ppreg;

  exec_dispatch u_dispatch (
    .d_val(d_val), .d_uop(d_uop), .d_rdy(d_rdy),
    .alu_val(alu_val), .alu_rdy(alu_rdy),
    .mul_val(mul_val), .mul_rdy(mul_rdy)
  );

  // Payload fans out to both units
  alu_unit u_alu (
    .clk(clk), .rst(rst),
    .in_val(alu_val), .in_rdy(alu_rdy), .in_pc(d_pc), .in_seq_num(d_seq_num),
    .in_op1(d_op1), .in_op2(d_op2), .in_waddr(d_waddr), .in_uop(d_uop),
    .in_preg(d_preg), .in_ppreg(d_ppreg),
    .out_val(ar_val), .out_rdy(ar_rdy), .out_pc(ar_pc), .out_seq_num(ar_seq_num),
    .out_waddr(ar_waddr), .out_preg(ar_preg), .out_ppreg(ar_ppreg), .out_wdata(ar_wdata)
  );

  mul_unit u_mul (
    .clk(clk), .rst(rst),
    .in_val(mul_val), .in_rdy(mul_rdy), .in_pc(d_pc), .in_seq_num(d_seq_num),
    .in_op1(d_op1), .in_op2(d_op2), .in_waddr(d_waddr), .in_uop(d_uop),
    .in_preg(d_preg), .in_ppreg(d_ppreg),
    .out_val(mr_val), .out_rdy(mr_rdy), .out_pc(mr_pc), .out_seq_num(mr_seq_num),
    .out_waddr(mr_waddr), .out_preg(mr_preg), .out_ppreg(mr_ppreg), .out_wdata(mr_wdata)
  );

  // ALU on a, multiplier on b
  wb_arbiter u_arb (
    .clk(clk), .rst(rst),
    .a_val(ar_val), .a_rdy(ar_rdy), .a_pc(ar_pc), .a_seq_num(ar_seq_num),
    .a_waddr(ar_waddr), .a_preg(ar_preg), .a_ppreg(ar_ppreg), .a_wdata(ar_wdata),
    .b_val(mr_val), .b_rdy(mr_rdy), .b_pc(mr_pc), .b_seq_num(mr_seq_num),
    .b_waddr(mr_waddr), .b_preg(mr_preg), .b_ppreg(mr_ppreg), .b_wdata(mr_wdata),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_preg(w_preg), .w_ppreg(w_ppreg), .w_wdata(w_wdata)
  );

endmodule

`default_nettype wire

//--- verif/exec_stage_tb.sv
// ----------------------------------------
// Random testbench for the execute stage
// Model table keyed by seq_num, tags must not wrap
// onto an op still in flight (256 tags)
// ----------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "exec_consts.svh"

module exec_stage_tb
  import exec_pkg::*;
();

  localparam int CLK_PERIOD  = 100;
  localparam int SEED        = 15618;
  localparam int NTAGS       = 1 << `SEQ_NUM_BITS;
  localparam int ISSUE_LIMIT = 400;   // Cycles an op may wait at d

  logic     clk, rst, d_val, d_rdy, w_val, w_rdy;
  word_t    d_pc, d_op1, d_op2, w_pc, w_wdata;
  seq_num_t d_seq_num, w_seq_num;
  areg_t    d_waddr, w_waddr;
  rv_uop    d_uop;
  preg_t    d_preg, d_ppreg, w_preg, w_ppreg;

  // ----------------------------------------
  // Model table and issue state
  // ----------------------------------------

  logic     exp_live  [NTAGS];   // Tag in flight
  word_t    exp_pc    [NTAGS];
  word_t    exp_wdata [NTAGS];
  areg_t    exp_waddr [NTAGS];
  preg_t    exp_preg  [NTAGS];
  preg_t    exp_ppreg [NTAGS];

  logic     have_op;             // Op held at d port
  word_t    cur_pc, cur_op1, cur_op2;
  rv_uop    cur_uop;
  areg_t    cur_waddr;
  preg_t    cur_preg, cur_ppreg;
  seq_num_t cur_seq, next_seq, ord_seq, watch_seq;
  logic     in_order, watch_on, mul_seen;
  int       pending;
  int       rdy_mode;            // 0 high, 1 random, 2 toggle
  string    test_name;

  exec_stage dut (
    .clk(clk), .rst(rst),
    .d_val(d_val), .d_rdy(d_rdy), .d_pc(d_pc), .d_seq_num(d_seq_num),
    .d_op1(d_op1), .d_op2(d_op2), .d_waddr(d_waddr), .d_uop(d_uop),
    .d_preg(d_preg), .d_ppreg(d_ppreg),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_preg(w_preg), .w_ppreg(w_ppreg), .w_wdata(w_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // Error handling and compare tasks
  // ----------------------------------------

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string field, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %h actual %h", test_name, field, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_seq(input string field, input seq_num_t exp, input seq_num_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %0d actual %0d", test_name, field, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_preg(input string field, input preg_t exp, input preg_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %0d actual %0d", test_name, field, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_areg(input string field, input areg_t exp, input areg_t act);
    if (act !== exp) begin
      $display("error %s %s: expected %0d actual %0d", test_name, field, exp, act);
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  function automatic word_t model_result(rv_uop uop, word_t pc, word_t a, word_t b);
    logic [2*`XLEN-1:0] prod;
    logic [2*`XLEN-1:0] ext;   // Sign-extended a for SRA
    logic [`XLEN:0]     diff;  // Top bit is the borrow of a - b
    word_t r;
    prod = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};
    ext  = {{`XLEN{a[`XLEN-1]}}, a} >> b[4:0];
    diff = {1'b0, a} - {1'b0, b};
    case (uop)
      OP_ADD:   r = a + b;
      OP_SUB:   r = a + ~b + 1'b1;   // Two's complement form
      OP_AND:   r = a & b;
      OP_OR:    r = a | b;
      OP_XOR:   r = a ^ b;
      OP_SLT:   r = {{(`XLEN-1){1'b0}},
                     (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : diff[`XLEN]};
      OP_SLTU:  r = {{(`XLEN-1){1'b0}}, diff[`XLEN]};
      OP_SRA:   r = ext[`XLEN-1:0];
      OP_SRL:   r = a >> b[4:0];
      OP_SLL:   r = a << b[4:0];
      OP_LUI:   r = b;
      OP_AUIPC: r = pc + b;
      OP_MUL:   r = prod[`XLEN-1:0];
      default:  r = prod[2*`XLEN-1:`XLEN];   // MULHU
    endcase
    return r;
  endfunction

  // Edge values about half the time
  function automatic word_t rand_operand();
    case ($urandom % 8)
      0:       return '0;
      1:       return '1;
      2:       return word_t'(1) << (`XLEN - 1);
      3:       return ~(word_t'(1) << (`XLEN - 1));
      default: return $urandom;
    endcase
  endfunction

  function automatic rv_uop pick_uop(input int mul_one_in);
    logic [3:0] code;
    code = 4'($urandom % 12);   // OP_ADD..OP_AUIPC
    if (mul_one_in > 0 && ($urandom % mul_one_in) == 0)
      return (($urandom % 2) == 0) ? OP_MUL : OP_MULHU;
    return rv_uop'(code);
  endfunction

  // ----------------------------------------
  // Cycle driver and monitor
  // ----------------------------------------

  task automatic record_issue();
    if (exp_live[d_seq_num]) begin
      $display("seq %0d issued again while still in flight", d_seq_num);
      stop_on_error();
    end
    exp_live[d_seq_num]  = 1'b1;
    exp_pc[d_seq_num]    = d_pc;
    exp_waddr[d_seq_num] = d_waddr;
    exp_preg[d_seq_num]  = d_preg;
    exp_ppreg[d_seq_num] = d_ppreg;
    exp_wdata[d_seq_num] = model_result(d_uop, d_pc, d_op1, d_op2);
    pending++;
    have_op = 1'b0;
  endtask

  task automatic check_writeback();
    seq_num_t s;
    s = w_seq_num;
    if (!exp_live[s]) begin
      $display("writeback of seq %0d which is not in flight (lost or duplicated)", s);
      stop_on_error();
    end
    if (in_order) begin
      check_seq("seq order", ord_seq, s);
      ord_seq = ord_seq + 1'b1;
    end
    check_word("pc", exp_pc[s], w_pc);
    check_areg("waddr", exp_waddr[s], w_waddr);
    check_preg("preg", exp_preg[s], w_preg);
    check_preg("ppreg", exp_ppreg[s], w_ppreg);
    check_word("wdata", exp_wdata[s], w_wdata);
    if (watch_on && s == watch_seq) mul_seen = 1'b1;
    exp_live[s] = 1'b0;
    pending--;
  endtask

  task automatic run_cycle();
    @(negedge clk);
    d_val     = have_op;
    d_pc      = cur_pc;
    d_seq_num = cur_seq;
    d_op1     = cur_op1;
    d_op2     = cur_op2;
    d_waddr   = cur_waddr;
    d_uop     = cur_uop;
    d_preg    = cur_preg;
    d_ppreg   = cur_ppreg;
    case (rdy_mode)
      0:       w_rdy = 1'b1;
      1:       w_rdy = ($urandom % 2) == 0;
      default: w_rdy = ~w_rdy;
    endcase
    #(CLK_PERIOD / 10);                    // Readies settled, edge still ahead
    if (d_val && d_rdy) record_issue();    // Both take effect on next rising edge
    if (w_val && w_rdy) check_writeback();
  endtask

  task automatic issue_op(input rv_uop uop, input word_t op1, input word_t op2);
    int waited;
    cur_uop   = uop;
    cur_op1   = op1;
    cur_op2   = op2;
    cur_pc    = word_t'($urandom) & ~word_t'(3);   // Word aligned
    cur_waddr = areg_t'($urandom);
    cur_preg  = preg_t'($urandom);
    cur_ppreg = preg_t'($urandom);
    cur_seq   = next_seq;
    next_seq  = next_seq + 1'b1;
    have_op   = 1'b1;
    waited    = 0;
    while (have_op) begin
      if (waited >= ISSUE_LIMIT) begin
        $display("op seq %0d was never accepted at the issue port", cur_seq);
        stop_on_error();
      end
      run_cycle();
      waited++;
    end
  endtask

  task automatic drain(input int limit);
    int waited;
    waited = 0;
    while (pending != 0) begin
      if (waited >= limit) begin
        $display("%s: %0d results never written back", test_name, pending);
        foreach (exp_live[i])
          if (exp_live[i]) $display("  seq %0d still pending", i);
        stop_on_error();
      end
      run_cycle();
      waited++;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    d_val = 1'b0;
    d_pc = '0;
    d_seq_num = '0;
    d_op1 = '0;
    d_op2 = '0;
    d_waddr = '0;
    d_uop = OP_ADD;
    d_preg = '0;
    d_ppreg = '0;
    w_rdy = 1'b1;
    have_op = 1'b0;
    cur_pc = '0;
    cur_op1 = '0;
    cur_op2 = '0;
    cur_uop = OP_ADD;
    cur_waddr = '0;
    cur_preg = '0;
    cur_ppreg = '0;
    cur_seq = '0;
    next_seq = '0;
    ord_seq = '0;
    watch_seq = '0;
    in_order = 1'b0;
    watch_on = 1'b0;
    mul_seen = 1'b0;
    pending = 0;
    rdy_mode = 0;
    foreach (exp_live[i]) exp_live[i] = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Idle after reset, both opcode classes on d_uop
    test_name = "reset_idle";
    repeat (20) begin
      cur_uop = (($urandom % 2) == 0) ? OP_MUL : OP_ADD;
      run_cycle();
      if (w_val !== 1'b0) begin
        $display("w_val went high with nothing issued");
        stop_on_error();
      end
      if (d_rdy !== 1'b1) begin
        $display("d_rdy low while both units are empty");
        stop_on_error();
      end
    end

    // ALU only, results come back in issue order
    test_name = "alu_random";
    in_order = 1'b1;
    ord_seq = next_seq;
    repeat (300) issue_op(pick_uop(0), rand_operand(), rand_operand());
    drain(100);
    in_order = 1'b0;

    test_name = "mul_mixed";
    repeat (60) begin
      issue_op((($urandom % 2) == 0) ? OP_MUL : OP_MULHU, rand_operand(), rand_operand());
      repeat (1 + $urandom % 3) issue_op(pick_uop(0), rand_operand(), rand_operand());
    end
    drain(200);

    test_name = "backpressure";
    rdy_mode = 1;
    repeat (250) issue_op(pick_uop(6), rand_operand(), rand_operand());
    drain(2000);

    // Multiply result must win a slot against a busy ALU stream
    test_name = "fairness";
    rdy_mode = 2;
    watch_seq = next_seq;
    watch_on = 1'b1;
    mul_seen = 1'b0;
    issue_op(OP_MUL, rand_operand(), rand_operand());
    repeat (60) issue_op(pick_uop(0), rand_operand(), rand_operand());
    if (!mul_seen) begin
      $display("multiply seq %0d starved behind the ALU stream", watch_seq);
      stop_on_error();
    end
    watch_on = 1'b0;
    drain(400);

    // Table empty, nothing more may come out
    test_name = "quiet_tail";
    repeat (40) begin
      run_cycle();
      if (w_val !== 1'b0) begin
        $display("w_val high after every issued op was written back");
        stop_on_error();
      end
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

//--- exec_stage.f
+incdir+design
design/exec_pkg.sv
design/exec_dispatch.sv
design/alu_unit.sv
design/mul_unit.sv
design/wb_arbiter.sv
design/exec_stage.sv
verif/exec_stage_tb.sv

//--- Makefile
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := exec_stage_tb
FILELIST  := exec_stage.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) design/exec_consts.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^PASS: all tests$$" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
